// ==== hdl/fx3_bus_pkg.sv ====
// GPIF II bus geometry and the state encoding of the slave-FIFO state machine.
// READ_LATENCY must be 2 or more. The read pipeline is one register shorter than
// the latency, and the output register adds the last cycle.

package fx3_bus_pkg;

  // ******************************
  // Bus widths
  // ******************************

  // Width of the GPIF data bus and of both FPGA-side streams
  localparam int DATA_W = 32;

  // GPIF address lines select one of four controller sockets
  localparam int ADDR_W = 2;

  // One ready flag per addressable socket
  localparam int FLAG_W = 4;

  // ******************************
  // Timing
  // ******************************

  // Cycles from a cycle with slrd_n low to the word on rd_data
  localparam int READ_LATENCY = 3;

  // One-hot so that each strobe decodes from a single state bit
  typedef enum logic [3:0] {
    ST_IDLE       = 4'b0001,
    ST_READ_START = 4'b0010,
    ST_READ_DATA  = 4'b0100,
    ST_WRITE_DATA = 4'b1000
  } gpif_state_t;

endpackage

// ==== hdl/fx3_ep_pkg.sv ====
// Endpoint numbering and the mapping of endpoints to ready flags.
// FLAGGED_EPS must not exceed the number of controller flags.

package fx3_ep_pkg;

  // ******************************
  // Endpoint numbering
  // ******************************

  // Width of the endpoint number from software
  localparam int EP_NUM_W = 5;

  // Endpoints 0 to EP_COUNT-1 have a direction bit, higher numbers are unknown
  localparam int EP_COUNT = 10;

  // Direction bit values
  // From host means the controller holds data, so the bridge reads it
  localparam logic DIR_FROM_HOST = 1'b0;
  localparam logic DIR_TO_HOST   = 1'b1;

  // ******************************
  // Flag mapping
  // ******************************

  // Endpoints below this number own a flag of their own
  localparam int FLAGGED_EPS = 4;

  // All other endpoints watch this shared flag
  localparam int SHARED_FLAG = 0;

endpackage

// ==== hdl/fx3_sel_if.sv ====
// Decoded endpoint selection passed from the selector to the state machine.
// Direction, flag and known bit are combinational, the address is registered.

interface fx3_sel_if;
  import fx3_bus_pkg::*;

  // Direction bit of the selected endpoint
  logic              cur_dir;
  // Ready flag that belongs to the selected endpoint
  logic              cur_flag;
  // Endpoint number lies inside the direction table
  logic              ep_known;
  // GPIF socket address, one cycle behind fifo_num
  logic [ADDR_W-1:0] addr;

  modport sel (
    output cur_dir,
    output cur_flag,
    output ep_known,
    output addr
  );

  modport fsm (
    input cur_dir,
    input cur_flag,
    input ep_known,
    input addr
  );

endinterface

// ==== hdl/fx3_ep_select.sv ====
// Endpoint decoder. Numbers at or above EP_COUNT are reported as unknown and
// never start a burst. Endpoints from FLAGGED_EPS upward share the flag SHARED_FLAG.

module fx3_ep_select (
  input  logic                              pclk,
  input  logic                              rst,
  input  logic [fx3_ep_pkg::EP_NUM_W-1:0]   fifo_num,
  input  logic [fx3_ep_pkg::EP_COUNT-1:0]   fifo_direction,
  input  logic [fx3_bus_pkg::FLAG_W-1:0]    fifo_rdy,
  output logic [fx3_bus_pkg::FLAG_W-1:0]    fifo_ready,
  fx3_sel_if.sel                            sel
);
  import fx3_bus_pkg::*;
  import fx3_ep_pkg::*;

  // ******************************
  // Direction and flag decode
  // ******************************

  // Unknown endpoints fall back to the read direction and the shared flag,
  // ep_known keeps them from starting anything
  always_comb begin
    sel.cur_dir  = DIR_FROM_HOST;
    sel.ep_known = 1'b0;
    for (int i = 0; i < EP_COUNT; i++) begin
      if (fifo_num == EP_NUM_W'(i)) begin
        sel.cur_dir  = fifo_direction[i];
        sel.ep_known = 1'b1;
      end
    end
  end

  always_comb begin
    sel.cur_flag = fifo_rdy[SHARED_FLAG];
    for (int i = 0; i < FLAGGED_EPS; i++) begin
      if (fifo_num == EP_NUM_W'(i)) begin
        sel.cur_flag = fifo_rdy[i];
      end
    end
  end

  // ******************************
  // Registered outputs
  // ******************************

  // The socket address is the low bits of the endpoint number
  always_ff @(posedge pclk) begin
    if (rst) begin
      sel.addr   <= '0;
      fifo_ready <= '0;
    end else begin
      sel.addr   <= fifo_num[ADDR_W-1:0];
      fifo_ready <= fifo_rdy;   // software view of the raw flags
    end
  end

endmodule

// ==== hdl/fx3_gpif_fsm.sv ====
// GPIF II slave-FIFO state machine. Strobes are decoded from the state without
// registers, so the controller sees them in the cycle the conditions hold.
// data_in is captured at the end of the READ_LATENCY-th cycle, counting the
// cycle with slrd_n low as the first. Words in flight drain even after idle.

module fx3_gpif_fsm (
  input  logic                             pclk,
  input  logic                             rst,
  input  logic                             trig,
  fx3_sel_if.fsm                           sel,
  input  logic [fx3_bus_pkg::DATA_W-1:0]   data_in,
  output logic [fx3_bus_pkg::DATA_W-1:0]   data_out,
  output logic                             data_oe,
  output logic                             slcs_n,
  output logic                             sloe_n,
  output logic                             slrd_n,
  output logic                             slwr_n,
  output logic                             pktend_n,
  output logic                             rd_valid,
  output logic                             rd_sop,
  output logic [fx3_bus_pkg::DATA_W-1:0]   rd_data,
  input  logic                             rd_ready,
  input  logic                             rd_eop,
  input  logic                             rd_eot,
  input  logic                             wr_valid,
  input  logic [fx3_bus_pkg::DATA_W-1:0]   wr_data,
  input  logic                             wr_eop,
  output logic                             wr_ready
);
  import fx3_bus_pkg::*;
  import fx3_ep_pkg::*;

  gpif_state_t             state;
  gpif_state_t             state_nxt;
  logic                    rd_take;
  logic                    wr_beat;
  logic                    wr_last;
  logic [READ_LATENCY-2:0] rd_pipe;
  logic                    rd_tap;
  logic                    first_word;

  // ******************************
  // State register and next state
  // ******************************

  // A low trigger level aborts any burst
  always_ff @(posedge pclk) begin
    if (rst || !trig) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        if (trig && sel.cur_flag && sel.ep_known) begin
          if (sel.cur_dir == DIR_TO_HOST) begin
            state_nxt = ST_WRITE_DATA;
          end else begin
            state_nxt = ST_READ_START;
          end
        end
      end
      ST_READ_START: state_nxt = ST_READ_DATA;
      ST_READ_DATA: begin
        if (rd_eot) begin
          state_nxt = ST_IDLE;
        end
      end
      ST_WRITE_DATA: begin
        if (wr_last) begin
          state_nxt = ST_IDLE;
        end
      end
      default: state_nxt = ST_IDLE;
    endcase
  end

  // ******************************
  // Bus strobes
  // ******************************

  // A read is issued only while the consumer has room and no end of packet
  assign rd_take = (state == ST_READ_DATA) && rd_ready && !rd_eop;

  // A write beat needs stream data and a ready controller socket
  assign wr_beat = (state == ST_WRITE_DATA) && wr_valid && sel.cur_flag;
  assign wr_last = wr_beat && wr_eop;

  assign slcs_n   = (state == ST_IDLE);
  assign sloe_n   = !((state == ST_READ_START) || (state == ST_READ_DATA));
  assign slrd_n   = !rd_take;
  assign slwr_n   = !wr_beat;
  assign pktend_n = !wr_last;

  // Bus is driven only during an actual write beat
  assign data_oe  = wr_beat;
  assign data_out = wr_data;
  assign wr_ready = (state == ST_WRITE_DATA) && sel.cur_flag;

  // ******************************
  // Read latency pipeline
  // ******************************

  // Each bit marks a read still travelling through the controller
  assign rd_tap = rd_pipe[READ_LATENCY-2];

  always_ff @(posedge pclk) begin
    if (rst) begin
      rd_pipe    <= '0;
      rd_valid   <= 1'b0;
      rd_sop     <= 1'b0;
      first_word <= 1'b1;
    end else begin
      rd_pipe  <= (rd_pipe << 1) | (READ_LATENCY - 1)'(rd_take);
      rd_valid <= rd_tap;
      rd_sop   <= rd_tap && first_word;
      // Rearmed in idle, cleared by the first word that comes back
      if (state == ST_IDLE) begin
        first_word <= 1'b1;
      end else if (rd_tap) begin
        first_word <= 1'b0;
      end
    end
  end

  always_ff @(posedge pclk) begin
    if (rd_tap) begin
      rd_data <= data_in;
    end
  end

endmodule

// ==== hdl/fx3_usb_bridge.sv ====
// Top level of the FX3 slave-FIFO bridge with plain ports only.
// The bidirectional data pad stays outside. data_oe high means drive data_out.

module fx3_usb_bridge (
  input  logic                             pclk,
  input  logic                             rst,

  // Controller side
  input  logic [fx3_bus_pkg::FLAG_W-1:0]   fifo_rdy,
  input  logic [fx3_bus_pkg::DATA_W-1:0]   data_in,
  output logic [fx3_bus_pkg::DATA_W-1:0]   data_out,
  output logic                             data_oe,
  output logic [fx3_bus_pkg::ADDR_W-1:0]   addr,
  output logic                             slcs_n,
  output logic                             sloe_n,
  output logic                             slrd_n,
  output logic                             slwr_n,
  output logic                             pktend_n,

  // Control
  input  logic [fx3_ep_pkg::EP_NUM_W-1:0]  fifo_num,
  input  logic [fx3_ep_pkg::EP_COUNT-1:0]  fifo_direction,
  input  logic                             trig,
  output logic [fx3_bus_pkg::FLAG_W-1:0]   fifo_ready,

  // Read stream toward the FPGA
  output logic                             rd_valid,
  output logic [fx3_bus_pkg::DATA_W-1:0]   rd_data,
  output logic                             rd_sop,
  input  logic                             rd_ready,
  input  logic                             rd_eop,
  input  logic                             rd_eot,

  // Write stream from the FPGA
  input  logic                             wr_valid,
  input  logic [fx3_bus_pkg::DATA_W-1:0]   wr_data,
  input  logic                             wr_eop,
  output logic                             wr_ready
);

  fx3_sel_if sel_bus ();

  fx3_ep_select fx3_ep_select_inst (
    .pclk           (pclk),
    .rst            (rst),
    .fifo_num       (fifo_num),
    .fifo_direction (fifo_direction),
    .fifo_rdy       (fifo_rdy),
    .fifo_ready     (fifo_ready),
    .sel            (sel_bus.sel)
  );

  fx3_gpif_fsm fx3_gpif_fsm_inst (
    .pclk     (pclk),
    .rst      (rst),
    .trig     (trig),
    .sel      (sel_bus.fsm),
    .data_in  (data_in),
    .data_out (data_out),
    .data_oe  (data_oe),
    .slcs_n   (slcs_n),
    .sloe_n   (sloe_n),
    .slrd_n   (slrd_n),
    .slwr_n   (slwr_n),
    .pktend_n (pktend_n),
    .rd_valid (rd_valid),
    .rd_sop   (rd_sop),
    .rd_data  (rd_data),
    .rd_ready (rd_ready),
    .rd_eop   (rd_eop),
    .rd_eot   (rd_eot),
    .wr_valid (wr_valid),
    .wr_data  (wr_data),
    .wr_eop   (wr_eop),
    .wr_ready (wr_ready)
  );

  // Socket address comes straight from the selector register
  assign addr = sel_bus.addr;

endmodule

// ==== verif/fx3_slave_model.sv ====
// Behavioral slave FIFO of the USB controller. Assumes READ_LATENCY of 3 or more.
// Read words come from a queue loaded through load_en, writes are captured while
// data_oe and slwr_n are active. An empty queue returns all ones.

module fx3_slave_model (
  input  logic                           pclk,
  input  logic                           rst,
  input  logic                           clear,
  input  logic                           load_en,
  input  logic [fx3_bus_pkg::DATA_W-1:0] load_word,
  input  logic                           slrd_n,
  input  logic                           slwr_n,
  input  logic                           pktend_n,
  input  logic                           data_oe,
  input  logic [fx3_bus_pkg::DATA_W-1:0] data_out,
  output logic [fx3_bus_pkg::DATA_W-1:0] data_in
);
  import fx3_bus_pkg::*;

  logic [DATA_W-1:0]       rd_q[$];
  logic [DATA_W-1:0]       wr_q[$];
  int                      rd_count;
  int                      pkt_end_idx;
  logic [READ_LATENCY-3:0] pend;

  // The word leaves the model one cycle before the bridge captures it
  always @(posedge pclk) begin
    if (rst || clear) begin
      rd_q.delete();
      wr_q.delete();
      rd_count    = 0;
      pkt_end_idx = -1;
      pend        <= '0;
      data_in     <= '0;
    end else begin
      if (load_en) begin
        rd_q.push_back(load_word);
      end
      pend <= (pend << 1) | (READ_LATENCY - 2)'(!slrd_n);
      if (pend[READ_LATENCY-3]) begin
        if (rd_q.size() > 0) begin
          data_in <= rd_q.pop_front();
        end else begin
          data_in <= '1;
        end
      end
      if (!slrd_n) begin
        rd_count = rd_count + 1;
      end
      // The bridge owns the pad only while data_oe is high
      if (data_oe && !slwr_n) begin
        wr_q.push_back(data_out);
        if (!pktend_n) begin
          pkt_end_idx = wr_q.size() - 1;
        end
      end
    end
  end

endmodule

// ==== verif/fx3_bridge_props.sv ====
// Concurrent checks on the GPIF strobes, bound into every fx3_gpif_fsm.

module fx3_bridge_props (
  input logic                     pclk,
  input logic                     rst,
  input logic                     slrd_n,
  input logic                     slwr_n,
  input logic                     sloe_n,
  input logic                     data_oe,
  input fx3_bus_pkg::gpif_state_t state
);
  import fx3_bus_pkg::*;

  // Read and write never share a cycle on the bus
  assert property (@(posedge pclk) disable iff (rst) !(!slrd_n && !slwr_n))
    else $error("slrd_n and slwr_n are both low");

  // The bridge never drives the pad while the controller drives it
  assert property (@(posedge pclk) disable iff (rst) data_oe |-> sloe_n)
    else $error("data_oe is high while sloe_n is low");

  assert property (@(posedge pclk) disable iff (rst) $onehot(state))
    else $error("state is not one-hot");

endmodule

bind fx3_gpif_fsm fx3_bridge_props props_inst (
  .pclk    (pclk),
  .rst     (rst),
  .slrd_n  (slrd_n),
  .slwr_n  (slwr_n),
  .sloe_n  (sloe_n),
  .data_oe (data_oe),
  .state   (state)
);

// ==== verif/tb_fx3_usb_bridge.sv ====
// Directed testbench for the slave-FIFO bridge. Inputs change on the rising
// edge and outputs are sampled on the falling edge.

module tb_fx3_usb_bridge;
  import fx3_bus_pkg::*;
  import fx3_ep_pkg::*;

  localparam int          READ_WORDS  = 8;
  localparam int          WRITE_WORDS = 6;
  localparam int          TIMEOUT     = 200;
  localparam logic [31:0] SEED        = 32'd51071;

  logic                pclk;
  logic                rst;
  logic [FLAG_W-1:0]   fifo_rdy;
  logic [DATA_W-1:0]   data_in;
  logic [DATA_W-1:0]   data_out;
  logic                data_oe;
  logic [ADDR_W-1:0]   addr;
  logic                slcs_n;
  logic                sloe_n;
  logic                slrd_n;
  logic                slwr_n;
  logic                pktend_n;
  logic [EP_NUM_W-1:0] fifo_num;
  logic [EP_COUNT-1:0] fifo_direction;
  logic                trig;
  logic [FLAG_W-1:0]   fifo_ready;
  logic                rd_valid;
  logic [DATA_W-1:0]   rd_data;
  logic                rd_sop;
  logic                rd_ready;
  logic                rd_eop;
  logic                rd_eot;
  logic                wr_valid;
  logic [DATA_W-1:0]   wr_data;
  logic                wr_eop;
  logic                wr_ready;
  logic                clear;
  logic                load_en;
  logic [DATA_W-1:0]   load_word;

  logic [31:0]         lcg_state;
  int                  err_count;
  int                  test_count;
  logic [DATA_W-1:0]   exp_q[$];
  logic [DATA_W-1:0]   rx_q[$];
  logic                sop_q[$];

  fx3_usb_bridge fx3_usb_bridge_inst (.*);

  fx3_slave_model slave_model_inst (
    .pclk      (pclk),
    .rst       (rst),
    .clear     (clear),
    .load_en   (load_en),
    .load_word (load_word),
    .slrd_n    (slrd_n),
    .slwr_n    (slwr_n),
    .pktend_n  (pktend_n),
    .data_oe   (data_oe),
    .data_out  (data_out),
    .data_in   (data_in)
  );

  initial begin
    pclk = 1'b0;
    forever #50 pclk = ~pclk;
  end

  // ******************************
  // Helpers
  // ******************************

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic compare_values(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_count++;
    if (err_count == errs_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, err_count - errs_before);
    end
  endtask

  task automatic check_strobes_high();
    compare_values("slcs_n", 32'(slcs_n), 32'd1);
    compare_values("sloe_n", 32'(sloe_n), 32'd1);
    compare_values("slrd_n", 32'(slrd_n), 32'd1);
    compare_values("slwr_n", 32'(slwr_n), 32'd1);
    compare_values("pktend_n", 32'(pktend_n), 32'd1);
  endtask

  // Empties the model and fills it and exp_q with n fresh words
  task automatic fill_model(input int n);
    logic [31:0] w;
    exp_q.delete();
    @(posedge pclk);
    clear <= 1'b1;
    @(posedge pclk);
    clear <= 1'b0;
    for (int i = 0; i < n; i++) begin
      w = next_random();
      exp_q.push_back(w);
      load_en   <= 1'b1;
      load_word <= w;
      @(posedge pclk);
    end
    load_en <= 1'b0;
  endtask

  // One cycle of the read stream, sampled on the falling edge
  task automatic step_read(inout int issued);
    @(negedge pclk);
    if (rd_valid) begin
      rx_q.push_back(rd_data);
      sop_q.push_back(rd_sop);
    end
    if (!slrd_n) begin
      issued++;
    end
  endtask

  // ******************************
  // Directed tests
  // ******************************

  task automatic test_reset_idle();
    int e;
    e = err_count;
    repeat (4) begin
      @(negedge pclk);
      check_strobes_high();
      compare_values("rd_valid", 32'(rd_valid), 32'd0);
      compare_values("rd_sop", 32'(rd_sop), 32'd0);
      compare_values("wr_ready", 32'(wr_ready), 32'd0);
      compare_values("data_oe", 32'(data_oe), 32'd0);
    end
    @(posedge pclk);
    fifo_num <= 5'd0;
    fifo_rdy <= '0;
    trig     <= 1'b1;
    repeat (4) begin
      @(negedge pclk);
      check_strobes_high();
    end
    @(posedge pclk);
    trig <= 1'b0;
    report_test("reset_idle", e);
  endtask

  task automatic run_read_burst(input string name, input bit throttle);
    int          e;
    int          issued;
    int          cnt;
    logic [31:0] r;
    e      = err_count;
    issued = 0;
    cnt    = 0;
    rx_q.delete();
    sop_q.delete();
    fill_model(READ_WORDS);
    fifo_num       <= 5'd1;
    fifo_direction <= '0;
    fifo_rdy       <= 4'b0010;
    trig           <= 1'b1;
    while (rx_q.size() < READ_WORDS && cnt < TIMEOUT) begin
      @(posedge pclk);
      r = next_random();
      if (issued >= READ_WORDS) begin
        rd_ready <= 1'b0;
      end else begin
        rd_ready <= throttle ? r[4] : 1'b1;
      end
      step_read(issued);
      cnt++;
    end
    if (rx_q.size() < READ_WORDS) begin
      $display("%s: timed out waiting for read words", name);
      err_count++;
    end
    @(posedge pclk);
    rd_eot   <= 1'b1;
    fifo_rdy <= '0;
    @(posedge pclk);
    rd_eot <= 1'b0;
    @(negedge pclk);
    check_strobes_high();
    compare_values("read count", 32'(issued), 32'(READ_WORDS));
    compare_values("model read count", 32'(slave_model_inst.rd_count), 32'(issued));
    compare_values("received count", 32'(rx_q.size()), 32'(READ_WORDS));
    for (int i = 0; i < rx_q.size() && i < exp_q.size(); i++) begin
      compare_values("rd_data", rx_q[i], exp_q[i]);
      compare_values("rd_sop", 32'(sop_q[i]), 32'(i == 0));
    end
    @(posedge pclk);
    trig <= 1'b0;
    report_test(name, e);
  endtask

  task automatic test_write_burst();
    int          e;
    int          i;
    int          cnt;
    bit          started;
    logic [31:0] r;
    e       = err_count;
    i       = 0;
    cnt     = 0;
    started = 1'b0;
    fill_model(0);
    for (int k = 0; k < WRITE_WORDS; k++) begin
      exp_q.push_back(next_random());
    end
    fifo_num       <= 5'd2;
    fifo_direction <= 10'b00_0000_0100;
    fifo_rdy       <= 4'b0100;
    trig           <= 1'b1;
    wr_valid       <= 1'b1;
    wr_data        <= exp_q[0];
    wr_eop         <= (WRITE_WORDS == 1);
    while (i < WRITE_WORDS && cnt < TIMEOUT) begin
      @(negedge pclk);
      cnt++;
      if (started) begin
        compare_values("wr_ready", 32'(wr_ready), 32'(fifo_rdy[2]));
      end
      if (wr_ready) begin
        compare_values("pktend_n", 32'(pktend_n), 32'(i != WRITE_WORDS - 1));
        started = 1'b1;
        i++;
      end
      @(posedge pclk);
      if (i < WRITE_WORDS) begin
        r = next_random();
        wr_data     <= exp_q[i];
        wr_eop      <= (i == WRITE_WORDS - 1);
        fifo_rdy[2] <= (r[3:0] != 4'd0);
      end else begin
        wr_valid <= 1'b0;
        wr_eop   <= 1'b0;
        fifo_rdy <= '0;
      end
    end
    if (i < WRITE_WORDS) begin
      $display("write_burst: timed out waiting for wr_ready");
      err_count++;
    end
    @(negedge pclk);
    check_strobes_high();
    compare_values("captured count", 32'(slave_model_inst.wr_q.size()), 32'(WRITE_WORDS));
    for (int k = 0; k < slave_model_inst.wr_q.size() && k < WRITE_WORDS; k++) begin
      compare_values("data_out", slave_model_inst.wr_q[k], exp_q[k]);
    end
    compare_values("pktend index", 32'(slave_model_inst.pkt_end_idx), 32'(WRITE_WORDS - 1));
    @(posedge pclk);
    trig <= 1'b0;
    report_test("write_burst", e);
  endtask

  task automatic test_endpoint_select();
    int e;
    int cnt;
    e = err_count;
    @(posedge pclk);
    fifo_num       <= 5'd6;
    fifo_rdy       <= 4'b1010;
    fifo_direction <= '0;
    @(posedge pclk);
    @(negedge pclk);
    compare_values("addr", 32'(addr), 32'd2);
    compare_values("fifo_ready", 32'(fifo_ready), 32'b1010);
    // Endpoint 6 has no own flag, so only flag 0 counts
    @(posedge pclk);
    fifo_rdy <= 4'b1110;
    trig     <= 1'b1;
    repeat (6) begin
      @(negedge pclk);
      check_strobes_high();
    end
    @(posedge pclk);
    fifo_rdy <= 4'b0001;
    cnt = 0;
    @(negedge pclk);
    while (sloe_n && cnt < TIMEOUT) begin
      @(negedge pclk);
      cnt++;
    end
    if (sloe_n) begin
      $display("endpoint_select: read burst on endpoint 6 never started");
      err_count++;
    end
    compare_values("wr_ready", 32'(wr_ready), 32'd0);
    @(posedge pclk);
    trig <= 1'b0;
    @(posedge pclk);
    fifo_direction <= 10'b00_0100_0000;
    trig           <= 1'b1;
    cnt = 0;
    @(negedge pclk);
    while (!wr_ready && cnt < TIMEOUT) begin
      @(negedge pclk);
      cnt++;
    end
    if (!wr_ready) begin
      $display("endpoint_select: write burst on endpoint 6 never started");
      err_count++;
    end
    compare_values("sloe_n", 32'(sloe_n), 32'd1);
    @(posedge pclk);
    trig <= 1'b0;
    // Endpoint 12 lies outside the direction table
    @(posedge pclk);
    fifo_num       <= 5'd12;
    fifo_rdy       <= 4'hf;
    fifo_direction <= '1;
    trig           <= 1'b1;
    repeat (8) begin
      @(negedge pclk);
      check_strobes_high();
      compare_values("wr_ready", 32'(wr_ready), 32'd0);
    end
    @(posedge pclk);
    trig     <= 1'b0;
    fifo_rdy <= '0;
    report_test("endpoint_select", e);
  endtask

  task automatic test_trig_abort();
    int e;
    int issued;
    int cnt;
    e      = err_count;
    issued = 0;
    cnt    = 0;
    rx_q.delete();
    sop_q.delete();
    fill_model(READ_WORDS);
    fifo_num       <= 5'd1;
    fifo_direction <= '0;
    fifo_rdy       <= 4'b0010;
    rd_ready       <= 1'b1;
    trig           <= 1'b1;
    while (issued < 3 && cnt < TIMEOUT) begin
      step_read(issued);
      cnt++;
    end
    if (issued < 3) begin
      $display("trig_abort: read burst never started");
      err_count++;
    end
    @(posedge pclk);
    trig <= 1'b0;
    step_read(issued);
    @(posedge pclk);
    @(negedge pclk);
    check_strobes_high();
    @(posedge pclk);
    rd_ready <= 1'b0;
    fifo_rdy <= '0;
    repeat (READ_LATENCY + 1) @(posedge pclk);
    report_test("trig_abort", e);
  endtask

  // ******************************
  // Main sequence
  // ******************************

  initial begin
    lcg_state      = SEED;
    err_count      = 0;
    test_count     = 0;
    rst            = 1'b1;
    fifo_rdy       = '0;
    fifo_num       = '0;
    fifo_direction = '0;
    trig           = 1'b0;
    rd_ready       = 1'b0;
    rd_eop         = 1'b0;
    rd_eot         = 1'b0;
    wr_valid       = 1'b0;
    wr_data        = '0;
    wr_eop         = 1'b0;
    clear          = 1'b0;
    load_en        = 1'b0;
    load_word      = '0;
    repeat (2) @(posedge pclk);
    rst <= 1'b0;

    test_reset_idle();
    run_read_burst("read_steady", 1'b0);
    run_read_burst("read_throttled", 1'b1);
    test_write_burst();
    test_endpoint_select();
    test_trig_abort();

    $display("%0d tests run, %0d errors", test_count, err_count);
    if (err_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
hdl/fx3_bus_pkg.sv
hdl/fx3_ep_pkg.sv
hdl/fx3_sel_if.sv
hdl/fx3_ep_select.sv
hdl/fx3_gpif_fsm.sv
hdl/fx3_usb_bridge.sv
verif/fx3_slave_model.sv
verif/fx3_bridge_props.sv
verif/tb_fx3_usb_bridge.sv

// ==== Makefile ====
# Verilator flow for the FX3 slave-FIFO bridge testbench
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_fx3_usb_bridge
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --Mdir $(BUILD_DIR) \
		--top-module $(TOP) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
